// File: logic/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // ------------------------------------------------------------
    // Major opcodes, inst[6:0]
    // ------------------------------------------------------------
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    // ------------------------------------------------------------
    // Minor codes, inst[14:12]
    // ------------------------------------------------------------
    // Arithmetic, shared by R and I forms
    localparam logic [2:0] f3Add  = 3'b000;
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Srl  = 3'b101;
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;
    // Branch conditions
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // ------------------------------------------------------------
    // Instruction formats, MSB first
    // ------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmt_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFmt_t;

    // Branch offset bits are scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;
        logic       imm11;
        logic [6:0] opcode;
    } bFmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFmt_t;

    // Jump offset, again bit 0 implied
    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;
        logic       imm11;
        logic [7:0] immHi;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFmt_t;

    // One word, six views
    typedef union packed {
        rFmt_t rFmt;
        iFmt_t iFmt;
        sFmt_t sFmt;
        bFmt_t bFmt;
        uFmt_t uFmt;
        jFmt_t jFmt;
    } instWord_t;

endpackage

`default_nettype wire

// File: logic/rvCtrlPkg.sv
`default_nettype none

package rvCtrlPkg;

    // ------------------------------------------------------------
    // ALU operation codes
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSll   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluSlt   = 4'd8,
        aluSltu  = 4'd9,
        aluPassB = 4'd10    // lui, operand B straight through
    } aluOp_t;

    // Write-back source
    typedef enum logic [1:0] {
        wbAlu  = 2'd0,
        wbLoad = 2'd1,
        wbPc4  = 2'd2
    } wbSel_t;

    // Upper 24 address bits of the IO page, 0xFFFFFC00..0xFFFFFCFF
    localparam logic [23:0] ioPageDefault = 24'hFFFFFC;

endpackage

`default_nettype wire

// File: logic/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
    input  rvIsaPkg::instWord_t inst,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic [4:0]          rd,
    output logic [2:0]          funct3,
    output logic [31:0]         imm,
    output rvCtrlPkg::aluOp_t   aluOp,
    output logic                aluSrc,
    output logic                regWrite,
    output logic                memRead,
    output logic                memWrite,
    output logic                isBranch,
    output logic                isJal,
    output logic                isJalr,
    output rvCtrlPkg::wbSel_t   wbSel
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [6:0] opcode;
    logic       altBit;

    // Register fields sit in the same place in every format
    assign opcode = inst.rFmt.opcode;
    assign rs1    = inst.rFmt.rs1;
    assign rs2    = inst.rFmt.rs2;
    assign rd     = inst.rFmt.rd;
    assign funct3 = inst.rFmt.funct3;
    // funct7 bit 5, sub and sra select
    assign altBit = inst.rFmt.funct7[5];

    // ------------------------------------------------------------
    // Control levels
    // ------------------------------------------------------------
    assign isBranch = (opcode == opBranch);
    assign isJal    = (opcode == opJal);
    assign isJalr   = (opcode == opJalr);
    assign memRead  = (opcode == opLoad);
    assign memWrite = (opcode == opStore);

    // Immediate feeds operand B
    assign aluSrc = (opcode == opI) || (opcode == opLoad) || (opcode == opStore) ||
                    (opcode == opLui) || (opcode == opAuipc) || (opcode == opJalr);

    // Everything but stores and branches writes rd
    assign regWrite = (opcode == opR) || (opcode == opI) || (opcode == opLoad) ||
                      (opcode == opLui) || (opcode == opAuipc) || isJal || isJalr;

    // Link value for jumps, load data for loads
    assign wbSel = (isJal || isJalr) ? wbPc4 : (memRead ? wbLoad : wbAlu);

    // ------------------------------------------------------------
    // Full ALU code from opcode, funct3 and funct7[5]
    // ------------------------------------------------------------
    always_comb begin
        aluOp = aluAdd;
        if (opcode == opR || opcode == opI) begin
            case (funct3)
                // Only the R form has sub
                f3Add:   aluOp = (opcode == opR && altBit) ? aluSub : aluAdd;
                f3Sll:   aluOp = aluSll;
                f3Slt:   aluOp = aluSlt;
                f3Sltu:  aluOp = aluSltu;
                f3Xor:   aluOp = aluXor;
                // srai keeps bit 30 in its imm field too
                f3Srl:   aluOp = altBit ? aluSra : aluSrl;
                f3Or:    aluOp = aluOr;
                default: aluOp = aluAnd;
            endcase
        end else if (isBranch) begin
            aluOp = aluSub;
        end else if (opcode == opLui) begin
            aluOp = aluPassB;
        end
    end

    // ------------------------------------------------------------
    // Sign-extended immediate, per format view
    // ------------------------------------------------------------
    always_comb begin
        case (opcode)
            opStore:  imm = {{20{inst.sFmt.immHi[6]}}, inst.sFmt.immHi, inst.sFmt.immLo};
            opBranch: imm = {{20{inst.bFmt.imm12}}, inst.bFmt.imm11, inst.bFmt.immHi,
                             inst.bFmt.immLo, 1'b0};
            opLui,
            opAuipc:  imm = {inst.uFmt.imm, 12'h000};
            opJal:    imm = {{12{inst.jFmt.imm20}}, inst.jFmt.immHi, inst.jFmt.imm11,
                             inst.jFmt.immLo, 1'b0};
            // I form, loads and jalr
            default:  imm = {{20{inst.iFmt.imm[11]}}, inst.iFmt.imm};
        endcase
    end

endmodule

`default_nettype wire

// File: logic/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute (
    input  logic [31:0]       opA,
    input  logic [31:0]       opB,
    input  rvCtrlPkg::aluOp_t aluOp,
    input  logic [2:0]        funct3,
    input  logic              isBranch,
    output logic [31:0]       aluResult,
    output logic              zero,
    output logic              branchTaken
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;
    logic       condMet;

    // Shift amount, low five bits only
    assign shamt = opB[4:0];

    // Shared compares for slt and branches
    assign ltSigned   = ($signed(opA) < $signed(opB));
    assign ltUnsigned = (opA < opB);

    // ------------------------------------------------------------
    // Operation
    // ------------------------------------------------------------
    always_comb begin
        case (aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluOr:    aluResult = opA | opB;
            aluXor:   aluResult = opA ^ opB;
            aluSll:   aluResult = opA << shamt;
            aluSrl:   aluResult = opA >> shamt;
            aluSra:   aluResult = $unsigned($signed(opA) >>> shamt);
            aluSlt:   aluResult = {31'd0, ltSigned};
            aluSltu:  aluResult = {31'd0, ltUnsigned};
            aluPassB: aluResult = opB;
            default:  aluResult = opA + opB;
        endcase
    end

    // Equality from the subtraction
    assign zero = (aluResult == 32'd0);

    // ------------------------------------------------------------
    // Branch condition
    // ------------------------------------------------------------
    always_comb begin
        case (funct3)
            f3Beq:   condMet = zero;
            f3Bne:   condMet = !zero;
            f3Blt:   condMet = ltSigned;
            f3Bge:   condMet = !ltSigned;
            f3Bltu:  condMet = ltUnsigned;
            f3Bgeu:  condMet = !ltUnsigned;
            // Reserved codes never branch
            default: condMet = 1'b0;
        endcase
    end

    assign branchTaken = isBranch && condMet;

endmodule

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wrEn,
    input  logic [31:0] wrData,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    // x1..x31 only, x0 has no storage
    logic [31:0] regs [1:31];

    // Write at the edge, x0 target dropped
    always_ff @(posedge clk) begin
        if (wrEn && rd != 5'd0) begin
            regs[rd] <= wrData;
        end
    end

    // Combinational reads
    assign rs1Data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    // Contents stay untouched while reset is low
    noWriteInReset: assert property (
        @(posedge clk) !arstN |-> !wrEn
    ) else $error("Register write enabled while reset is low");

endmodule

`default_nettype wire

// File: logic/memIoResult.sv
`timescale 1ns/1ps
`default_nettype none

module memIoResult #(
    parameter int          dmemWords = 256,
    parameter logic [23:0] ioPage    = rvCtrlPkg::ioPageDefault
) (
    input  logic              clk,
    input  logic              arstN,
    input  logic [31:0]       addr,
    input  logic [31:0]       storeData,
    input  logic              memRead,
    input  logic              memWrite,
    input  rvCtrlPkg::wbSel_t wbSel,
    input  logic [31:0]       pcPlus4,
    input  logic [31:0]       ioRdData,
    output logic [31:0]       wbData,
    output logic              ioRead,
    output logic              ioWrite,
    output logic [7:0]        ioAddr,
    output logic [31:0]       ioWrData
);
    import rvCtrlPkg::*;

    localparam int idxW = (dmemWords > 1) ? $clog2(dmemWords) : 1;

    logic [31:0]     dmem [dmemWords];
    logic            ioHit;
    logic [31:0]     wordSel;
    logic [idxW-1:0] wordIdx;
    logic [31:0]     loadData;

    // ------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------
    // Page match on the upper 24 bits
    assign ioHit = (addr[31:8] == ioPage);

    // Word index, wraps at the memory depth
    assign wordSel = (addr >> 2) % dmemWords;
    assign wordIdx = wordSel[idxW-1:0];

    // IO strobes, one per access cycle
    assign ioRead   = memRead && ioHit;
    assign ioWrite  = memWrite && ioHit;
    assign ioAddr   = addr[7:0];
    assign ioWrData = storeData;

    // ------------------------------------------------------------
    // Data memory
    // ------------------------------------------------------------
    // Stores off the page only
    always_ff @(posedge clk) begin
        if (memWrite && !ioHit) begin
            dmem[wordIdx] <= storeData;
        end
    end

    // IO data wins on a page hit
    assign loadData = ioHit ? ioRdData : dmem[wordIdx];

    // Write-back select
    always_comb begin
        case (wbSel)
            wbLoad:  wbData = loadData;
            wbPc4:   wbData = pcPlus4;
            default: wbData = addr;
        endcase
    end

    // One instruction never both reads and writes the page
    ioExclusive: assert property (
        @(posedge clk) disable iff (!arstN) !(ioRead && ioWrite)
    ) else $error("ioRead and ioWrite raised in the same cycle");

endmodule

`default_nettype wire

// File: logic/rvCore.sv
`timescale 1ns/1ps
`default_nettype none

module rvCore #(
    parameter int          dmemWords = 256,
    parameter logic [23:0] ioPage    = rvCtrlPkg::ioPageDefault
) (
    input  logic        clk,
    input  logic        arstN,
    output logic [31:0] instAddr,
    input  logic [31:0] inst,
    input  logic [31:0] ioRdData,
    output logic        ioRead,
    output logic        ioWrite,
    output logic [7:0]  ioAddr,
    output logic [31:0] ioWrData
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic [31:0] nextPc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [31:0] imm;
    aluOp_t      aluOp;
    wbSel_t      wbSel;
    logic        aluSrc;
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    logic        isBranch;
    logic        isJal;
    logic        isJalr;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluResult;
    logic        branchTaken;
    logic [31:0] wbData;
    // Write enables, held off during reset
    logic        regWrEn;
    logic        memRdEn;
    logic        memWrEn;

    // ------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------
    assign instAddr = pc;
    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;

    // jalr clears bit 0, jal and taken branches go PC relative
    always_comb begin
        if (isJalr) begin
            nextPc = {aluResult[31:1], 1'b0};
        end else if (isJal || branchTaken) begin
            nextPc = pcTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= 32'd0;
        end else begin
            pc <= nextPc;
        end
    end

    assign regWrEn = regWrite && arstN;
    assign memRdEn = memRead && arstN;
    assign memWrEn = memWrite && arstN;

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    instDecoder uDecoder (
        .inst     (inst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .funct3   (funct3),
        .imm      (imm),
        .aluOp    (aluOp),
        .aluSrc   (aluSrc),
        .regWrite (regWrite),
        .memRead  (memRead),
        .memWrite (memWrite),
        .isBranch (isBranch),
        .isJal    (isJal),
        .isJalr   (isJalr),
        .wbSel    (wbSel)
    );

    regFile uRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wrEn    (regWrEn),
        .wrData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    // auipc adds to PC, everything else to rs1
    assign opA = (inst[6:0] == opAuipc) ? pc : rs1Data;
    assign opB = aluSrc ? imm : rs2Data;

    aluExecute uAlu (
        .opA         (opA),
        .opB         (opB),
        .aluOp       (aluOp),
        .funct3      (funct3),
        .isBranch    (isBranch),
        .aluResult   (aluResult),
        .zero        (),
        .branchTaken (branchTaken)
    );

    memIoResult #(
        .dmemWords (dmemWords),
        .ioPage    (ioPage)
    ) uMemIo (
        .clk       (clk),
        .arstN     (arstN),
        .addr      (aluResult),
        .storeData (rs2Data),
        .memRead   (memRdEn),
        .memWrite  (memWrEn),
        .wbSel     (wbSel),
        .pcPlus4   (pcPlus4),
        .ioRdData  (ioRdData),
        .wbData    (wbData),
        .ioRead    (ioRead),
        .ioWrite   (ioWrite),
        .ioAddr    (ioAddr),
        .ioWrData  (ioWrData)
    );

endmodule

`default_nettype wire

// File: test/rvCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb;
    import rvIsaPkg::*;

    localparam int romWords  = 256;
    localparam int waitLimit = 2000;
    // Store that ends every program
    localparam logic [7:0] doneOff = 8'hFC;
    // x31 holds the IO page base
    localparam logic [4:0] ioBase = 5'd31;
    // Word access code for lw and sw
    localparam logic [2:0] f3Word = 3'b010;

    logic        clk;
    logic        arstN;
    logic [31:0] instAddr;
    logic [31:0] inst;
    logic [31:0] ioRdData;
    logic        ioRead;
    logic        ioWrite;
    logic [7:0]  ioAddr;
    logic [31:0] ioWrData;

    logic [31:0] rom [romWords];
    logic [31:0] prog [$];
    logic [7:0]  expAddr [$];
    logic [31:0] expData [$];
    logic [7:0]  gotAddr [$];
    logic [31:0] gotData [$];
    logic        doneSeen;
    int          readCount;
    logic [7:0]  lastReadAddr;
    int          errors;

    rvCore #(
        .dmemWords (256)
    ) DUT (
        .clk      (clk),
        .arstN    (arstN),
        .instAddr (instAddr),
        .inst     (inst),
        .ioRdData (ioRdData),
        .ioRead   (ioRead),
        .ioWrite  (ioWrite),
        .ioAddr   (ioAddr),
        .ioWrData (ioWrData)
    );

    // Instruction ROM, word indexed, answers in the same cycle
    assign inst = rom[instAddr[9:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
        instWord_t w;
        w.rFmt = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: opR};
        return w;
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm12);
        instWord_t w;
        w.iFmt = '{imm: imm12, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    // sw data, off(base)
    function automatic logic [31:0] encS(input logic [4:0] base, input logic [4:0] data,
                                         input logic [11:0] off);
        instWord_t w;
        w.sFmt = '{immHi: off[11:5], rs2: data, rs1: base, funct3: f3Word,
                   immLo: off[4:0], opcode: opStore};
        return w;
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
        instWord_t w;
        w.bFmt = '{imm12: off[12], immHi: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
                   immLo: off[4:1], imm11: off[11], opcode: opBranch};
        return w;
    endfunction

    function automatic logic [31:0] encU(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm20);
        instWord_t w;
        w.uFmt = '{imm: imm20, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] off);
        instWord_t w;
        w.jFmt = '{imm20: off[20], immLo: off[10:1], imm11: off[11], immHi: off[19:12],
                   rd: rd, opcode: opJal};
        return w;
    endfunction

    // ------------------------------------------------------------
    // Reference results from the RV32I rules
    // ------------------------------------------------------------
    function automatic logic [31:0] arithRef(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] x, input logic [31:0] y);
        case (f3)
            f3Add:   return alt ? x - y : x + y;
            f3Sll:   return x << y[4:0];
            f3Slt:   return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            f3Sltu:  return (x < y) ? 32'd1 : 32'd0;
            f3Xor:   return x ^ y;
            f3Srl:   return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
            f3Or:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] x,
                                       input logic [31:0] y);
        case (f3)
            f3Beq:   return x == y;
            f3Bne:   return x != y;
            f3Blt:   return $signed(x) < $signed(y);
            f3Bge:   return $signed(x) >= $signed(y);
            f3Bltu:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Program building
    // ------------------------------------------------------------
    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // Byte address of the next emitted word
    function automatic logic [31:0] curPc();
        return 32'(prog.size() * 4);
    endfunction

    // lui plus addi, upper part rounded for the signed low half
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] val);
        logic [31:0] hi;
        hi = val + 32'h800;
        emit(encU(opLui, rd, hi[31:12]));
        emit(encI(opI, f3Add, rd, rd, val[11:0]));
    endtask

    task automatic ioStore(input logic [4:0] rs, input logic [7:0] off);
        emit(encS(ioBase, rs, {4'd0, off}));
    endtask

    task automatic expectIo(input logic [7:0] off, input logic [31:0] data);
        expAddr.push_back(off);
        expData.push_back(data);
    endtask

    task automatic startProgram();
        prog.delete();
        expAddr.delete();
        expData.delete();
        // addi x31, x0, -1024 gives 0xFFFFFC00
        emit(encI(opI, f3Add, ioBase, 5'd0, 12'hC00));
    endtask

    // Done marker, then park on a jump to self
    task automatic finishProgram();
        ioStore(5'd0, doneOff);
        emit(encJ(5'd0, 21'd0));
    endtask

    task automatic checkWord(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    // Load ROM under reset, run to the done store, compare the IO trace
    task automatic runProgram(input string name);
        int i;
        int cycles;
        @(posedge clk);
        arstN <= 1'b0;
        for (i = 0; i < prog.size(); i++) begin
            rom[8'(i)] <= prog[i];
        end
        gotAddr.delete();
        gotData.delete();
        readCount = 0;
        doneSeen = 1'b0;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        cycles = 0;
        // Strobes sampled mid-cycle
        while (!doneSeen && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            if (ioWrite) begin
                if (ioAddr == doneOff) begin
                    doneSeen = 1'b1;
                end else begin
                    gotAddr.push_back(ioAddr);
                    gotData.push_back(ioWrData);
                end
            end
            if (ioRead) begin
                readCount++;
                lastReadAddr = ioAddr;
            end
        end
        assert (doneSeen) else begin
            errors++;
            $display("%s: program never reached its done store within %0d cycles",
                     name, waitLimit);
        end
        checkWord({name, " store count"}, 32'(expAddr.size()), 32'(gotAddr.size()));
        for (i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
            checkWord($sformatf("%s store %0d addr", name, i), {24'd0, expAddr[i]},
                      {24'd0, gotAddr[i]});
            checkWord($sformatf("%s store %0d data", name, i), expData[i], gotData[i]);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic testArith();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm12;
        logic [2:0]  f3;
        logic        alt;
        logic [7:0]  off;
        int          k;
        startProgram();
        a = $urandom();
        b = $urandom();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        off = 8'd0;
        // Eight funct3 codes, then sub and sra
        for (k = 0; k < 10; k++) begin
            f3 = (k == 9) ? f3Srl : 3'(k % 8);
            alt = (k >= 8);
            emit(encR({1'b0, alt, 5'd0}, f3, 5'd3, 5'd1, 5'd2));
            ioStore(5'd3, off);
            expectIo(off, arithRef(f3, alt, a, b));
            off = off + 8'd4;
        end
        // Immediate forms, srai last
        for (k = 0; k < 9; k++) begin
            f3 = (k == 8) ? f3Srl : 3'(k);
            alt = (k == 8);
            imm12 = 12'($urandom());
            if (f3 == f3Sll || f3 == f3Srl) begin
                imm12 = {1'b0, alt, 5'd0, imm12[4:0]};
            end
            emit(encI(opI, f3, 5'd4, 5'd1, imm12));
            ioStore(5'd4, off);
            expectIo(off, arithRef(f3, alt, a, {{20{imm12[11]}}, imm12}));
            off = off + 8'd4;
        end
        finishProgram();
        runProgram("arith");
    endtask

    task automatic testMemory();
        logic [11:0] memOff [4] = '{12'h040, 12'h080, 12'h100, 12'h3FC};
        logic [31:0] vals [4];
        int          k;
        startProgram();
        for (k = 0; k < 4; k++) begin
            vals[k] = $urandom();
            loadConst(5'd5, vals[k]);
            emit(encS(5'd0, 5'd5, memOff[k]));
        end
        // Read back after all stores, each to its own IO slot
        for (k = 0; k < 4; k++) begin
            emit(encI(opLoad, f3Word, 5'd6, 5'd0, memOff[k]));
            ioStore(5'd6, 8'(k * 4));
            expectIo(8'(k * 4), vals[k]);
        end
        finishProgram();
        runProgram("memory");
    endtask

    task automatic testIoRead();
        logic [31:0] rdVal;
        rdVal = $urandom();
        @(posedge clk);
        ioRdData <= rdVal;
        startProgram();
        emit(encI(opLoad, f3Word, 5'd7, ioBase, 12'h020));
        ioStore(5'd7, 8'h24);
        expectIo(8'h24, rdVal);
        finishProgram();
        runProgram("ioRead");
        checkWord("ioRead strobe count", 32'd1, 32'(readCount));
        checkWord("ioRead read addr", 32'h20, {24'd0, lastReadAddr});
    endtask

    task automatic testControl();
        logic [2:0]  brF3 [6] = '{f3Beq, f3Bne, f3Blt, f3Bge, f3Bltu, f3Bgeu};
        logic [4:0]  pairA [3] = '{5'd1, 5'd2, 5'd1};
        logic [4:0]  pairB [3] = '{5'd2, 5'd1, 5'd1};
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] vA;
        logic [31:0] vB;
        logic [31:0] jumpPc;
        logic [7:0]  off;
        int          k;
        int          p;
        startProgram();
        // Negative against small positive splits signed from unsigned
        a = 32'hFFFF_FFFB;
        b = 32'd3;
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        emit(encI(opI, f3Add, 5'd10, 5'd0, 12'h05A));
        off = 8'd0;
        for (k = 0; k < 6; k++) begin
            for (p = 0; p < 3; p++) begin
                vA = (pairA[p] == 5'd1) ? a : b;
                vB = (pairB[p] == 5'd1) ? a : b;
                // Taken skips the first marker
                emit(encB(brF3[k], pairA[p], pairB[p], 13'd8));
                ioStore(5'd10, off);
                ioStore(5'd10, off + 8'd4);
                if (!branchRef(brF3[k], vA, vB)) begin
                    expectIo(off, 32'h5A);
                end
                expectIo(off + 8'd4, 32'h5A);
                off = off + 8'd8;
            end
        end
        // jal over one marker, link stored
        jumpPc = curPc();
        emit(encJ(5'd11, 21'd8));
        ioStore(5'd10, 8'hA0);
        ioStore(5'd11, 8'hA4);
        expectIo(8'hA4, jumpPc + 32'd4);
        // jalr with an odd offset, bit 0 dropped from the target
        jumpPc = curPc();
        emit(encU(opAuipc, 5'd12, 20'd0));
        emit(encI(opJalr, 3'b000, 5'd13, 5'd12, 12'd13));
        ioStore(5'd10, 8'hA8);
        ioStore(5'd13, 8'hAC);
        expectIo(8'hAC, jumpPc + 32'd8);
        finishProgram();
        runProgram("control");
    endtask

    task automatic testUpperX0();
        logic [19:0] immA;
        logic [19:0] immB;
        logic [31:0] upPc;
        startProgram();
        immA = 20'($urandom());
        immB = 20'($urandom());
        upPc = curPc();
        emit(encU(opAuipc, 5'd14, immA));
        ioStore(5'd14, 8'h00);
        expectIo(8'h00, upPc + {immA, 12'h000});
        emit(encU(opLui, 5'd15, immB));
        ioStore(5'd15, 8'h04);
        expectIo(8'h04, {immB, 12'h000});
        // Writes aimed at x0
        emit(encI(opI, f3Add, 5'd0, 5'd0, 12'h07B));
        emit(encU(opLui, 5'd0, immA));
        emit(encR(7'd0, f3Add, 5'd16, 5'd0, 5'd0));
        ioStore(5'd0, 8'h08);
        expectIo(8'h08, 32'd0);
        ioStore(5'd16, 8'h0C);
        expectIo(8'h0C, 32'd0);
        finishProgram();
        runProgram("upperX0");
    endtask

    // ------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------
    initial begin
        int i;
        arstN = 1'b0;
        ioRdData = 32'd0;
        errors = 0;
        lastReadAddr = 8'd0;
        // Park every word on a jump to itself
        for (i = 0; i < romWords; i++) begin
            rom[8'(i)] = encJ(5'd0, 21'd0);
        end
        void'($urandom(71018));
        testArith();
        testMemory();
        testIoRead();
        testControl();
        testUpperX0();
        $display("Errors counted: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/rvIsaPkg.sv
logic/rvCtrlPkg.sv
logic/instDecoder.sv
logic/aluExecute.sv
logic/regFile.sv
logic/memIoResult.sv
logic/rvCore.sv
test/rvCoreTb.sv

// File: Makefile
# Verilator simulation of the RV32I core slice

VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASSMSG   ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
